/* Bender.yml */
package:
  name: instruction_decoder

sources:
  - source/decoderPkg.sv
  - source/opClassIf.sv
  - source/regFieldIf.sv
  - source/opcodeClassifier.sv
  - source/registerFields.sv
  - source/operandFormer.sv
  - source/instructionDecoder.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/instructionDecoderTb.sv

/* source/decoderPkg.sv */
/*
 * Decoder package
 * Widths, register codes, micro-op codes and the enums shared by the
 * 16-bit instruction decoder.
 */
package decoderPkg;

	typedef logic [15:0] instrWordT;
	typedef logic [5:0] regCodeT;
	typedef logic [32:0] immT;
	typedef logic [7:0] uCmdT;
	typedef logic [7:0] uIxtT;
	typedef logic [5:0] subOpT;
	// bit 2 unsigned, low bits b/w/l/q
	typedef logic [2:0] accessT;

	typedef enum logic [5:0] {
		opNop, opInvalid, opMovRm, opMovMr, opMovIr, opAlu3, opAluCmp, opConvRr,
		opBra, opBsr, opJmp, opJsr, opOpIxt, opMovRc, opMovCr, opLeaMr
	} opT;

	typedef enum logic [4:0] {
		formInvalid, formZ, formReg, formRegReg, formImm8Reg, formImm8Z, formImm8N,
		formRegStReg, formLdRegReg, formRegStDrReg, formLdDrRegReg, formImm4ZReg,
		formImm4NReg, formPcDisp8, formImm12Z, formImm12N, formRegStDi4Sp,
		formLdDi4SpReg
	} formT;

	typedef enum logic [3:0] {
		tySb, tySw, tySl, tySq, tyUb, tyUw, tyUl, tyUq, tyNb
	} operandTypeT;

	typedef enum logic [1:0] {
		condAlways, condIfTrue, condIfFalse
	} condT;

	// special registers
	localparam regCodeT regDlr = 6'h20;
	localparam regCodeT regPc = 6'h22;
	localparam regCodeT regGbr = 6'h23;
	localparam regCodeT regLr = 6'h24;
	localparam regCodeT regImm = 6'h2E;
	localparam regCodeT regSp = 6'h2F;
	localparam regCodeT regZzr = 6'h3F;

	localparam accessT accSb = 3'b000;
	localparam accessT accSw = 3'b001;
	localparam accessT accSl = 3'b010;
	localparam accessT accSq = 3'b011;
	localparam accessT accUb = 3'b100;
	localparam accessT accUw = 3'b101;
	localparam accessT accUl = 3'b110;

	// alu and compare sub-ops
	localparam subOpT aluAdd = 6'h00;
	localparam subOpT aluSub = 6'h01;
	localparam subOpT aluAdc = 6'h02;
	localparam subOpT aluSbb = 6'h03;
	localparam subOpT aluTst = 6'h04;
	localparam subOpT aluAnd = 6'h05;
	localparam subOpT aluOr = 6'h06;
	localparam subOpT aluXor = 6'h07;
	localparam subOpT aluCmpEq = 6'h0C;
	localparam subOpT aluCmpHi = 6'h0D;
	localparam subOpT aluCmpGt = 6'h0E;
	localparam subOpT aluCmpGe = 6'h0F;
	localparam subOpT aluCmpQHi = 6'h1D;
	localparam subOpT aluCmpQGt = 6'h1E;

	// conversions
	localparam subOpT convMov = 6'h00;
	localparam subOpT convExtUb = 6'h04;
	localparam subOpT convExtUw = 6'h05;
	localparam subOpT convExtSb = 6'h06;
	localparam subOpT convExtSw = 6'h07;

	// load immediate
	localparam subOpT ldiLdix = 6'h00;
	localparam subOpT ldiLdish8 = 6'h01;
	localparam subOpT ldiLdish16 = 6'h02;

	// system ops
	localparam subOpT ixtSleep = 6'h02;
	localparam subOpT ixtBreak = 6'h03;
	localparam subOpT ixtClrt = 6'h04;
	localparam subOpT ixtSett = 6'h05;
	localparam subOpT ixtClrs = 6'h06;
	localparam subOpT ixtSets = 6'h07;
	localparam subOpT ixtNott = 6'h08;
	localparam subOpT ixtNots = 6'h09;
	localparam subOpT ixtRte = 6'h0C;

endpackage

/* source/instructionDecoder.sv */
/*
 * Instruction decoder top
 * Classifies and expands one 16-bit word per clock and registers the
 * decoded micro-op, one cycle of latency.
 */
`timescale 1ns/1ns

module instructionDecoder (
	input logic clock,
	input logic rstN,
	input decoderPkg::instrWordT istrWord,
	output decoderPkg::regCodeT regN,
	output decoderPkg::regCodeT regM,
	output decoderPkg::regCodeT regO,
	output decoderPkg::immT imm,
	output decoderPkg::uCmdT uCmd,
	output decoderPkg::uIxtT uIxt,
	output logic invalid
);
	import decoderPkg::*;

	opClassIf cls ();
	regFieldIf regs ();

	regCodeT nextN, nextM, nextO;
	immT nextImm;
	uCmdT nextUCmd;
	uIxtT nextUIxt;
	logic nextInvalid;

	opcodeClassifier classifier (.istrWord(istrWord), .cls(cls.classifier));

	registerFields expander (.istrWord(istrWord), .regs(regs.expander));

	operandFormer former (
		.istrWord(istrWord), .cls(cls.former), .regs(regs.former),
		.regN(nextN), .regM(nextM), .regO(nextO), .imm(nextImm),
		.uCmd(nextUCmd), .uIxt(nextUIxt), .invalid(nextInvalid)
	);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			regN <= regZzr;
			regM <= regZzr;
			regO <= regZzr;
			imm <= '0;
			uCmd <= {condAlways, opNop};
			uIxt <= '0;
			invalid <= 1'b0;
		end else begin
			regN <= nextN;
			regM <= nextM;
			regO <= nextO;
			imm <= nextImm;
			uCmd <= nextUCmd;
			uIxt <= nextUIxt;
			invalid <= nextInvalid;
		end
	end

endmodule

/* source/opClassIf.sv */
/*
 * Opcode class bundle
 * Operation, form, size, operand type, condition and sub-op of one word.
 */
`timescale 1ns/1ns

interface opClassIf;
	import decoderPkg::*;

	opT op;
	formT form;
	accessT access;
	operandTypeT operandType;
	condT cond;
	subOpT subOp;

	modport classifier(output op, form, access, operandType, cond, subOp);
	modport former(input op, form, access, operandType, cond, subOp);

endinterface

/* source/opcodeClassifier.sv */
/*
 * Opcode classifier
 * Matches the opcode pattern and yields operation, form, access size,
 * operand type, condition and sub-op.
 */
`timescale 1ns/1ns

module opcodeClassifier (
	input decoderPkg::instrWordT istrWord,
	opClassIf.classifier cls
);
	import decoderPkg::*;

	always_comb begin
		cls.op = opInvalid;
		cls.form = formInvalid;
		cls.access = '0;
		cls.operandType = tySb;
		cls.cond = condAlways;
		cls.subOp = '0;

		casez (istrWord)
			16'h0???: begin
				// bits 11..10 pick store/load and plain/indexed
				cls.access = {1'b0, istrWord[9:8]};
				case (istrWord[11:10])
					2'b00: begin
						cls.op = opMovRm;
						cls.form = formRegStReg;
					end
					2'b01: begin
						cls.op = opMovRm;
						cls.form = formRegStDrReg;
					end
					2'b10: begin
						cls.op = opMovMr;
						cls.form = formLdRegReg;
					end
					default: begin
						cls.op = opMovMr;
						cls.form = formLdDrRegReg;
					end
				endcase
				if (istrWord == 16'h0000) begin
					cls.op = opNop;
					cls.form = formZ;
				end
			end
			16'h1???: begin
				cls.form = formRegReg;
				cls.op = opAlu3;
				cls.operandType = tyNb;
				case (istrWord[11:8])
					4'h0: cls.subOp = aluAdd;
					4'h1: cls.subOp = aluSub;
					4'h2: cls.subOp = aluAdc;
					4'h3: cls.subOp = aluSbb;
					4'h4: begin
						cls.op = opAluCmp;
						cls.operandType = tySb;
						cls.subOp = aluTst;
					end
					4'h5: cls.subOp = aluAnd;
					4'h6: cls.subOp = aluOr;
					4'h7: cls.subOp = aluXor;
					4'h8, 4'h9, 4'hA, 4'hB: begin
						// moves mixing general and extended banks
						cls.op = opConvRr;
						cls.operandType = operandTypeT'({2'b00, istrWord[9:8]});
						cls.subOp = convMov;
					end
					4'hC, 4'hD, 4'hE: begin
						cls.op = opAluCmp;
						cls.operandType = tySb;
						cls.subOp = (istrWord[9:8] == 2'b00) ? aluCmpEq :
							(istrWord[9:8] == 2'b01) ? aluCmpHi : aluCmpGt;
					end
					default: begin
						cls.op = opInvalid;
						cls.form = formInvalid;
						cls.operandType = tySb;
					end
				endcase
			end
			16'h20??, 16'h22??, 16'h23??: begin
				cls.op = opBra;
				cls.form = formPcDisp8;
				cls.access = accSw;
				if (istrWord[9])
					cls.cond = istrWord[8] ? condIfFalse : condIfTrue;
			end
			16'h21??: begin
				cls.op = opBsr;
				cls.form = formPcDisp8;
				cls.access = accSw;
			end
			16'h24??, 16'h25??, 16'h26??: begin
				cls.op = opMovIr;
				cls.form = (istrWord[9:8] == 2'b01) ? formImm8N : formImm8Z;
				cls.subOp = istrWord[9] ? ldiLdish8 : ldiLdix;
			end
			16'h28??, 16'h29??, 16'h2A??, 16'h2B??: begin
				cls.op = istrWord[9] ? opMovMr : opMovRm;
				cls.form = istrWord[9] ? formLdDi4SpReg : formRegStDi4Sp;
				cls.access = istrWord[8] ? accSq : accSl;
			end
			16'h2C??, 16'h2D??, 16'h2E??, 16'h2F??: begin
				cls.op = opAluCmp;
				cls.form = (istrWord[9:8] == 2'b01) ? formImm4NReg : formImm4ZReg;
				cls.subOp = (istrWord[9:8] == 2'b10) ? aluCmpGt :
					(istrWord[9:8] == 2'b11) ? aluCmpGe : aluCmpEq;
			end
			16'h30?0: begin
				cls.form = formZ;
				cls.op = opOpIxt;
				case (istrWord[7:4])
					4'h0: cls.op = opNop;
					4'h1: cls.op = opJmp;
					4'h2: cls.subOp = ixtSleep;
					4'h3: cls.subOp = ixtBreak;
					4'h4: cls.subOp = ixtClrt;
					4'h5: cls.subOp = ixtSett;
					4'h6: cls.subOp = ixtClrs;
					4'h7: cls.subOp = ixtSets;
					4'h8: cls.subOp = ixtNott;
					4'h9: cls.subOp = ixtNots;
					4'hA, 4'hB: begin
						cls.op = opMovIr;
						cls.subOp = ldiLdish16;
					end
					4'hC: cls.subOp = ixtRte;
					default: begin
						cls.op = opInvalid;
						cls.form = formInvalid;
					end
				endcase
			end
			16'h32?0, 16'h32?1, 16'h32?2, 16'h32?3: begin
				cls.op = istrWord[1:0] == 2'b01 ? opJsr : opJmp;
				cls.form = formReg;
				if (istrWord[1])
					cls.cond = istrWord[0] ? condIfFalse : condIfTrue;
			end
			16'h32?4, 16'h32?5, 16'h32?6, 16'h32?7: begin
				cls.op = opConvRr;
				cls.form = formReg;
				cls.operandType = tySl;
				cls.subOp = {4'h1, istrWord[1:0]};
			end
			16'h48??, 16'h49??, 16'h4A??, 16'h4B??: begin
				cls.op = istrWord[8] ? opMovCr : opMovRc;
				cls.form = formRegReg;
				cls.operandType = operandTypeT'({2'b01, istrWord[9:8]});
			end
			16'h50??, 16'h51??, 16'h52??, 16'h53??: begin
				cls.op = opMovMr;
				cls.form = istrWord[9] ? formLdDrRegReg : formLdRegReg;
				cls.access = istrWord[8] ? accUw : accUb;
			end
			16'h58??, 16'h59??, 16'h5B??, 16'h5C??, 16'h5D??, 16'h5E??, 16'h5F??: begin
				cls.op = opAlu3;
				cls.form = formRegReg;
				case (istrWord[10:8])
					3'h0: cls.subOp = aluAdd;
					3'h1: cls.subOp = aluSub;
					3'h3: cls.subOp = aluCmpQHi;
					3'h4: cls.subOp = aluCmpQGt;
					3'h5: cls.subOp = aluAnd;
					3'h6: cls.subOp = aluOr;
					default: cls.subOp = aluXor;
				endcase
				if (istrWord[10:8] == 3'h3 || istrWord[10:8] == 3'h4)
					cls.op = opAluCmp;
			end
			16'h8???: begin
				if (istrWord[10:8] != 3'b000) begin
					// displacement forms
					cls.op = istrWord[11] ? opMovMr : opMovRm;
					cls.form = istrWord[11] ? formLdRegReg : formRegStReg;
					cls.access = accSl;
					cls.operandType = tyUl;
				end else begin
					cls.op = istrWord[11] ? opMovMr : opMovRm;
					cls.form = istrWord[11] ? formLdDrRegReg : formRegStDrReg;
					cls.access = accUl;
				end
			end
			16'hA???, 16'hB???: begin
				cls.op = opMovIr;
				cls.form = istrWord[12] ? formImm12N : formImm12Z;
				cls.subOp = ldiLdix;
			end
			16'hC???: begin
				cls.op = opAlu3;
				cls.form = formImm8Reg;
				cls.subOp = aluAdd;
			end
			16'hD???: begin
				cls.op = opMovIr;
				cls.form = formImm8Reg;
			end
			default: begin
				cls.op = opInvalid;
				cls.form = formInvalid;
			end
		endcase
	end

endmodule

/* source/operandFormer.sv */
/*
 * Operand former
 * Picks register codes, immediate and extended command per form.
 */
`timescale 1ns/1ns

module operandFormer (
	input decoderPkg::instrWordT istrWord,
	opClassIf.former cls,
	regFieldIf.former regs,
	output decoderPkg::regCodeT regN,
	output decoderPkg::regCodeT regM,
	output decoderPkg::regCodeT regO,
	output decoderPkg::immT imm,
	output decoderPkg::uCmdT uCmd,
	output decoderPkg::uIxtT uIxt,
	output logic invalid
);
	import decoderPkg::*;

	immT imm8Sx;
	uIxtT memIxt;
	uIxtT memIxtByte;
	uIxtT opIxt;
	logic isLoad;

	assign imm8Sx = {{25{istrWord[7]}}, istrWord[7:0]};
	assign isLoad = (cls.form == formLdRegReg) || (cls.form == formLdDrRegReg) ||
		(cls.form == formLdDi4SpReg) || (cls.form == formPcDisp8);
	assign memIxt = {cls.cond, cls.access[1:0], isLoad, cls.access};
	// pc/gbr base indexes by byte
	assign memIxtByte = {cls.cond, cls.access[1:0], isLoad, cls.access[2], 2'b00};
	assign opIxt = {cls.cond, cls.subOp};

	assign uCmd = {cls.cond, cls.op};
	assign invalid = (cls.form == formInvalid);

	always_comb begin
		regN = regZzr;
		regM = regZzr;
		regO = regZzr;
		imm = '0;
		uIxt = opIxt;

		case (cls.form)
			formZ: begin
				if (cls.op == opJmp)
					regM = regLr;
				if (cls.op == opMovIr)
					imm = {17'b0, {16{istrWord[4]}}};
			end
			formReg: begin
				regN = regs.gprN;
				if (cls.operandType == tySl)
					regM = regs.gprN;
				else
					regO = regs.gprN;
			end
			formRegReg: begin
				regN = regs.gprN;
				regM = regs.gprM;
				regO = regDlr;
				case (cls.operandType)
					tySw: regM = regs.extM;
					tySl: regN = regs.extN;
					tySq: begin
						regN = regs.extN;
						regM = regs.extM;
					end
					tyUb: regN = regs.ctlN;
					tyUw: regM = regs.ctlM;
					tyUl: regN = regs.sysN;
					tyUq: regM = regs.sysM;
					tyNb: begin
						regM = regs.gprN;
						regO = regs.gprM;
					end
					default: regO = regDlr;
				endcase
			end
			formImm8Reg: begin
				imm = imm8Sx;
				regN = regs.gprO;
				regM = regImm;
				regO = regs.gprO;
			end
			formImm8Z, formImm8N: begin
				imm = {{25{cls.form == formImm8N}}, istrWord[7:0]};
				regN = regDlr;
				regM = regImm;
			end
			formImm12Z, formImm12N: begin
				imm = {{21{cls.form == formImm12N}}, istrWord[11:0]};
				regN = regDlr;
				regM = regImm;
			end
			formImm4ZReg, formImm4NReg: begin
				imm = {{29{cls.form == formImm4NReg}}, istrWord[3:0]};
				regN = regs.gprN;
				regM = regImm;
			end
			formRegStReg, formLdRegReg: begin
				// stores swap the roles of N and M
				regN = (cls.form == formRegStReg) ? regs.gprM : regs.gprN;
				regM = (cls.form == formRegStReg) ? regs.gprN : regs.gprM;
				uIxt = memIxt;
				if (cls.operandType == tyUl) begin
					regO = regImm;
					imm = {30'b0, istrWord[10:8]};
				end
			end
			formRegStDrReg: begin
				regN = regs.gprM;
				regO = regDlr;
				regM = regs.nIsLow ? (regs.nIsR1 ? regGbr : regPc) : regs.gprN;
				uIxt = regs.nIsLow ? memIxtByte : memIxt;
			end
			formLdDrRegReg: begin
				regN = regs.gprN;
				regO = regDlr;
				regM = regs.mIsLow ? (regs.mIsR1 ? regGbr : regPc) : regs.gprM;
				uIxt = regs.mIsLow ? memIxtByte : memIxt;
			end
			formPcDisp8: begin
				regN = regDlr;
				regM = regPc;
				regO = regImm;
				imm = imm8Sx;
				uIxt = memIxt;
			end
			formRegStDi4Sp, formLdDi4SpReg: begin
				regN = regs.gprN;
				regM = regSp;
				regO = regImm;
				imm = {28'b0, cls.access[2], istrWord[3:0]};
				uIxt = memIxt;
			end
			default: uIxt = opIxt;
		endcase
	end

endmodule

/* source/regFieldIf.sv */
/*
 * Register field bundle
 * General, extended, control and status codes of the three fields.
 */
`timescale 1ns/1ns

interface regFieldIf;
	import decoderPkg::*;

	regCodeT gprN, gprM, gprO;
	regCodeT extN, extM, extO;
	regCodeT ctlN, ctlM;
	regCodeT sysN, sysM;
	logic nIsLow, nIsR1, mIsLow, mIsR1;

	modport expander(output gprN, gprM, gprO, extN, extM, extO, ctlN, ctlM,
		sysN, sysM, nIsLow, nIsR1, mIsLow, mIsR1);
	modport former(input gprN, gprM, gprO, extN, extM, extO, ctlN, ctlM,
		sysN, sysM, nIsLow, nIsR1, mIsLow, mIsR1);

endinterface

/* source/registerFields.sv */
/*
 * Register field expander
 * Turns the O, N and M fields into general, extended, control and
 * status register codes.
 */
`timescale 1ns/1ns

module registerFields (
	input decoderPkg::instrWordT istrWord,
	regFieldIf.expander regs
);
	import decoderPkg::*;

	logic [3:0] fieldO, fieldN, fieldM;
	logic rsvO, rsvN, rsvM;

	assign fieldO = istrWord[11:8];
	assign fieldN = istrWord[7:4];
	assign fieldM = istrWord[3:0];

	// r0, r1 and r15 are remapped to the special bank
	assign rsvO = (fieldO[3:1] == 3'b000) || (fieldO == 4'hF);
	assign rsvN = (fieldN[3:1] == 3'b000) || (fieldN == 4'hF);
	assign rsvM = (fieldM[3:1] == 3'b000) || (fieldM == 4'hF);

	assign regs.gprO = {rsvO, 1'b0, fieldO};
	assign regs.gprN = {rsvN, 1'b0, fieldN};
	assign regs.gprM = {rsvM, 1'b0, fieldM};

	assign regs.extO = {rsvO, 1'b1, fieldO};
	assign regs.extN = {rsvN, 1'b1, fieldN};
	assign regs.extM = {rsvM, 1'b1, fieldM};

	assign regs.ctlN = {2'b10, fieldN};
	assign regs.ctlM = {2'b10, fieldM};
	assign regs.sysN = {2'b11, fieldN};
	assign regs.sysM = {2'b11, fieldM};

	// base selection for indexed forms
	assign regs.nIsLow = (fieldN[3:1] == 3'b000);
	assign regs.nIsR1 = regs.nIsLow && fieldN[0];
	assign regs.mIsLow = (fieldM[3:1] == 3'b000);
	assign regs.mIsR1 = regs.mIsLow && fieldM[0];

endmodule

/* include/decoderModel.svh */
/*
 * Decoder reference model
 * Expected register codes, immediates and command bytes of the decoder.
 */
`ifndef DECODER_MODEL_SVH
`define DECODER_MODEL_SVH

// regN, regM, regO, imm, uCmd, uIxt, invalid
typedef logic [67:0] decodeT;

function automatic decodeT packDecode(regCodeT n, regCodeT m, regCodeT o, immT value,
	uCmdT cmd, uIxtT ixt, logic inv);
	return {n, m, o, value, cmd, ixt, inv};
endfunction

function automatic decodeT invalidDecode();
	return packDecode(regZzr, regZzr, regZzr, '0, {condAlways, opInvalid}, '0, 1'b1);
endfunction

// r0, r1 and r15 live in the special bank
function automatic logic isReserved(logic [3:0] f);
	return (f <= 4'h1) || (f == 4'hF);
endfunction

function automatic regCodeT gprCode(logic [3:0] f);
	return {isReserved(f), 1'b0, f};
endfunction

function automatic regCodeT extCode(logic [3:0] f);
	return {isReserved(f), 1'b1, f};
endfunction

// index base of the indexed memory forms
function automatic regCodeT baseCode(logic [3:0] f);
	if (f == 4'h0)
		return regPc;
	if (f == 4'h1)
		return regGbr;
	return gprCode(f);
endfunction

function automatic uIxtT memIxt(logic [1:0] cond, logic [2:0] size, logic isLoad);
	return {cond, size[1:0], isLoad, size};
endfunction

// low bits kept, the rest filled
function automatic immT extendImm(logic [32:0] value, int width, logic fill);
	immT result;
	for (int i = 0; i < 33; i++)
		result[i] = (i < width) ? value[i] : fill;
	return result;
endfunction

function automatic decodeT streamDecode(instrWordT w);
	case (w[15:12])
		4'hA, 4'hB: return packDecode(regDlr, regImm, regZzr, extendImm(w[11:0], 12, w[12]),
			{condAlways, opMovIr}, {condAlways, ldiLdix}, 1'b0);
		4'hC: return packDecode(gprCode(w[11:8]), regImm, gprCode(w[11:8]),
			extendImm(w[7:0], 8, w[7]), {condAlways, opAlu3}, {condAlways, aluAdd}, 1'b0);
		default: return invalidDecode();
	endcase
endfunction

`endif

/* tests/instructionDecoderTb.sv */
/*
 * Instruction decoder testbench
 * Directed tests over the kept instruction groups, dropped opcodes and a
 * back-to-back random stream.
 */
`timescale 1ns/1ns

module instructionDecoderTb;
	import decoderPkg::*;

	`include "decoderModel.svh"

	localparam int clockPeriod = 20;
	localparam int streamLength = 64;
	localparam int directedWords = 48 + 3 * 22 + 6 * 8 + 4 * 4 + 3 + 3 * 8;
	// two cycles per directed word, one per streamed word, reset and margin
	localparam int watchdogCycles = 2 * directedWords + streamLength + 4 + 100;

	logic clock;
	logic rstN;
	instrWordT istrWord;
	regCodeT regN, regM, regO;
	immT imm;
	uCmdT uCmd;
	uIxtT uIxt;
	logic invalid;
	int errorCount;
	int reportedErrors;
	int checkCount;
	int testCount;
	int seed;

	instructionDecoder DUT (
		.clock(clock), .rstN(rstN), .istrWord(istrWord), .regN(regN), .regM(regM),
		.regO(regO), .imm(imm), .uCmd(uCmd), .uIxt(uIxt), .invalid(invalid)
	);

	always #(clockPeriod / 2) clock = ~clock;

	task automatic reportMismatch(input string name, input instrWordT word,
		input logic [32:0] expected, input logic [32:0] actual);
		errorCount++;
		$display("CHECK FAILED %s for word 0x%h: expected 0x%h, got 0x%h",
			name, word, expected, actual);
	endtask

	task automatic checkDecode(input instrWordT word, input decodeT expected);
		regCodeT expN, expM, expO;
		immT expImm;
		uCmdT expCmd;
		uIxtT expIxt;
		logic expInv;
		{expN, expM, expO, expImm, expCmd, expIxt, expInv} = expected;
		checkCount++;
		assert (regN === expN) else reportMismatch("regN", word, expN, regN);
		assert (regM === expM) else reportMismatch("regM", word, expM, regM);
		assert (regO === expO) else reportMismatch("regO", word, expO, regO);
		assert (imm === expImm) else reportMismatch("imm", word, expImm, imm);
		assert (uCmd === expCmd) else reportMismatch("uCmd", word, expCmd, uCmd);
		assert (uIxt === expIxt) else reportMismatch("uIxt", word, expIxt, uIxt);
		assert (invalid === expInv) else reportMismatch("invalid", word, expInv, invalid);
	endtask

	// one word in, its decode checked after the next edge
	task automatic applyWord(input instrWordT word, input decodeT expected);
		@(posedge clock);
		#2 istrWord = word;
		@(posedge clock);
		#2 checkDecode(word, expected);
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == reportedErrors)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errorCount - reportedErrors);
		reportedErrors = errorCount;
	endtask

	task automatic resetValues();
		decodeT idle;
		idle = packDecode(regZzr, regZzr, regZzr, '0, {condAlways, opNop}, '0, 1'b0);
		repeat (4) @(posedge clock);
		#2 checkDecode(istrWord, idle);
		rstN = 1'b1;
		@(posedge clock);
		#2 checkDecode(istrWord, idle);
		finishTest("reset");
	endtask

	task automatic loadsAndStores();
		logic [1:0] kind, size;
		logic [3:0] fn, fm;
		logic byteBase;
		regCodeT expN, expM, expO;
		uIxtT ixt;
		for (int i = 0; i < 48; i++) begin
			kind = $urandom_range(3, 0);
			size = $urandom_range(3, 0);
			fn = $urandom_range(15, 0);
			fm = $urandom_range(15, 0);
			// first words pin the index fields to r0 and r1
			if (i < 8) begin
				kind = {i[0], 1'b1};
				fn = {3'b000, i[1]};
				fm = {3'b000, i[2]};
			end
			if ({kind, size, fn, fm} == 12'h000)
				fm = 4'h5;
			ixt = memIxt(condAlways, {1'b0, size}, kind[1]);
			expO = kind[0] ? regDlr : regZzr;
			if (kind[1]) begin
				expN = gprCode(fn);
				expM = kind[0] ? baseCode(fm) : gprCode(fm);
				byteBase = kind[0] && fm <= 4'h1;
			end else begin
				expN = gprCode(fm);
				expM = kind[0] ? baseCode(fn) : gprCode(fn);
				byteBase = kind[0] && fn <= 4'h1;
			end
			if (byteBase)
				ixt = ixt & 8'hFC;
			applyWord({4'h0, kind, size, fn, fm}, packDecode(expN, expM, expO, '0,
				{condAlways, kind[1] ? opMovMr : opMovRm}, ixt, 1'b0));
		end
		finishTest("loads and stores");
	endtask

	task automatic aluAndCompares();
		logic [7:0] group;
		logic [3:0] fn, fm;
		regCodeT expN, expM, expO;
		opT op;
		subOpT sub;
		for (int rep = 0; rep < 3; rep++) begin
			for (int g = 0; g < 24; g++) begin
				group = (g < 16) ? 8'h10 + g : 8'h48 + g;
				if (group == 8'h1F || group == 8'h5A)
					continue;
				fn = $urandom_range(15, 0);
				fm = $urandom_range(15, 0);
				expN = gprCode(fn);
				expM = gprCode(fm);
				expO = regDlr;
				op = opAlu3;
				case (group)
					8'h10, 8'h58: sub = aluAdd;
					8'h11, 8'h59: sub = aluSub;
					8'h12: sub = aluAdc;
					8'h13: sub = aluSbb;
					8'h14: sub = aluTst;
					8'h15, 8'h5D: sub = aluAnd;
					8'h16, 8'h5E: sub = aluOr;
					8'h17, 8'h5F: sub = aluXor;
					8'h1C: sub = aluCmpEq;
					8'h1D: sub = aluCmpHi;
					8'h1E: sub = aluCmpGt;
					8'h5B: sub = aluCmpQHi;
					8'h5C: sub = aluCmpQGt;
					default: sub = convMov;
				endcase
				if (group >= 8'h10 && group <= 8'h17 && group != 8'h14) begin
					expM = gprCode(fn);
					expO = gprCode(fm);
				end
				if (group == 8'h14 || (group >= 8'h1C && group <= 8'h1E) ||
					group == 8'h5B || group == 8'h5C)
					op = opAluCmp;
				// sw, sl and sq moves take the extended bank
				if (group >= 8'h18 && group <= 8'h1B) begin
					op = opConvRr;
					if (group[0])
						expM = extCode(fm);
					if (group[1])
						expN = extCode(fn);
				end
				applyWord({group, fn, fm}, packDecode(expN, expM, expO, '0,
					{condAlways, op}, {condAlways, sub}, 1'b0));
			end
		end
		finishTest("alu and compares");
	endtask

	task automatic immediateForms();
		logic [31:0] rnd;
		logic [2:0] size;
		instrWordT word;
		immT value;
		regCodeT expN, expM, expO;
		uCmdT cmd;
		uIxtT ixt;
		for (int rep = 0; rep < 6; rep++) begin
			for (int kind = 0; kind < 8; kind++) begin
				rnd = $urandom();
				expN = regDlr;
				expM = regImm;
				expO = regZzr;
				cmd = {condAlways, opMovIr};
				ixt = {condAlways, ldiLdix};
				case (kind)
					0, 1: begin
						word = {3'b101, kind[0], rnd[11:0]};
						value = extendImm(rnd[11:0], 12, kind[0]);
					end
					2, 3: begin
						word = {7'b0010010, kind[0], rnd[7:0]};
						value = extendImm(rnd[7:0], 8, kind[0]);
					end
					4: begin
						word = {4'hC, rnd[11:0]};
						value = extendImm(rnd[7:0], 8, rnd[7]);
						expN = gprCode(rnd[11:8]);
						expO = gprCode(rnd[11:8]);
						cmd = {condAlways, opAlu3};
						ixt = {condAlways, aluAdd};
					end
					5, 6: begin
						word = {7'b0010110, kind == 6, rnd[7:0]};
						value = extendImm(rnd[3:0], 4, kind == 6);
						expN = gprCode(rnd[7:4]);
						cmd = {condAlways, opAluCmp};
						ixt = {condAlways, aluCmpEq};
					end
					default: begin
						// sp displacement, long or quad
						word = {6'b001010, rnd[9:0]};
						size = rnd[8] ? 3'b011 : 3'b010;
						value = extendImm({size[2], rnd[3:0]}, 5, 1'b0);
						expN = gprCode(rnd[7:4]);
						expM = regSp;
						expO = regImm;
						cmd = {condAlways, rnd[9] ? opMovMr : opMovRm};
						ixt = memIxt(condAlways, size, rnd[9]);
					end
				endcase
				applyWord(word, packDecode(expN, expM, expO, value, cmd, ixt, 1'b0));
			end
		end
		finishTest("immediates");
	endtask

	task automatic branchesAndSystem();
		logic [7:0] disp;
		condT cond;
		for (int i = 0; i < 16; i++) begin
			disp = $urandom_range(255, 0);
			cond = (i[1:0] == 2'd2) ? condIfTrue : (i[1:0] == 2'd3) ? condIfFalse : condAlways;
			applyWord({6'b001000, i[1:0], disp}, packDecode(regDlr, regPc, regImm,
				extendImm(disp, 8, disp[7]), {cond, (i[1:0] == 2'd1) ? opBsr : opBra},
				memIxt(cond, 3'b001, 1'b1), 1'b0));
		end
		applyWord(16'h3010, packDecode(regZzr, regLr, regZzr, '0, {condAlways, opJmp},
			'0, 1'b0));
		applyWord(16'h3040, packDecode(regZzr, regZzr, regZzr, '0, {condAlways, opOpIxt},
			{condAlways, ixtClrt}, 1'b0));
		applyWord(16'h30C0, packDecode(regZzr, regZzr, regZzr, '0, {condAlways, opOpIxt},
			{condAlways, ixtRte}, 1'b0));
		finishTest("branches and system");
	endtask

	task automatic invalidAndStream();
		instrWordT sent[$];
		instrWordT word;
		logic [3:0] top;
		for (int i = 0; i < 24; i++) begin
			top = (i % 3 == 0) ? 4'h9 : (i % 3 == 1) ? 4'hE : 4'h6;
			applyWord({top, 12'($urandom())}, invalidDecode());
		end
		@(posedge clock);
		#2;
		for (int i = 0; i <= streamLength; i++) begin
			if (i > 0) begin
				word = sent.pop_front();
				checkDecode(word, streamDecode(word));
			end
			if (i < streamLength) begin
				case ($urandom_range(4, 0))
					0: top = 4'hA;
					1: top = 4'hB;
					2: top = 4'hC;
					3: top = 4'h9;
					default: top = 4'hE;
				endcase
				istrWord = {top, 12'($urandom())};
				sent.push_back(istrWord);
			end
			@(posedge clock);
			#2;
		end
		finishTest("invalid and stream");
	endtask

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("watchdog expired after %0d cycles", watchdogCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		istrWord = '0;
		errorCount = 0;
		reportedErrors = 0;
		checkCount = 0;
		testCount = 0;
		seed = 32'h351c_730c;
		void'($urandom(seed));
		resetValues();
		loadsAndStores();
		aluAndCompares();
		immediateForms();
		branchesAndSystem();
		invalidAndStream();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
source/decoderPkg.sv
source/opClassIf.sv
source/regFieldIf.sv
source/opcodeClassifier.sv
source/registerFields.sv
source/operandFormer.sv
source/instructionDecoder.sv
tests/instructionDecoderTb.sv
